// File: Bender.yml
package:
  name: iq_dir_detector

sources:
  - include_dirs:
      - include
    files:
      - src/iq_dir_pkg.sv
      - src/cordic_block.sv
      - src/rotation.sv
      - src/system.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/system_assert.sv
      - verif/system_checker.sv
      - verif/system_tb.sv

// File: include/iq_dir_config.svh
`ifndef IQ_DIR_CONFIG_SVH
`define IQ_DIR_CONFIG_SVH

// Width of each signed I and Q component
`define IQ_WIDTH 4

// Unsigned phase angle width
// Full scale is one turn, so the angle wraps at 2**ANGLE_WIDTH
`define ANGLE_WIDTH 16

// Unrolled vectoring stages in the CORDIC
// The arctangent table in cordic_block holds one entry per stage
`define CORDIC_STAGES 12

`endif

// File: sim.f
+incdir+include
src/iq_dir_pkg.sv
src/cordic_block.sv
src/rotation.sv
src/system.sv
verif/system_assert.sv
verif/system_checker.sv
verif/system_tb.sv

// File: src/cordic_block.sv
`include "iq_dir_config.svh"

// Vectoring CORDIC that turns an I/Q sample into its phase angle
// The vector is first folded into the right half-plane, then each
// stage rotates it toward the I axis by +/- atan(2**-k) and keeps
// the sum of those rotations in the angle accumulator
module cordic_block (
	input  logic                   clock,
	input  logic                   reset,
	input  iq_dir_pkg::iq_sample_t i_sample,
	output iq_dir_pkg::angle_t     o_angle
);

	localparam int STAGES = `CORDIC_STAGES;

	// One fraction bit per stage below the input LSB
	localparam int FRAC_BITS = `CORDIC_STAGES;

	// Two headroom bits cover the corner magnitude and the CORDIC gain
	localparam int WORK_WIDTH = `IQ_WIDTH + FRAC_BITS + 2;
	localparam int EXT_BITS = WORK_WIDTH - `IQ_WIDTH - FRAC_BITS;

	localparam iq_dir_pkg::angle_t HALF_TURN = {1'b1, {(`ANGLE_WIDTH - 1){1'b0}}};

	// atan(2**-k) in angle units of 65536 counts per turn
	localparam iq_dir_pkg::angle_t ATAN_LUT [STAGES] = '{
		16'd8192,
		16'd4836,
		16'd2555,
		16'd1297,
		16'd651,
		16'd326,
		16'd163,
		16'd81,
		16'd41,
		16'd20,
		16'd10,
		16'd5
	};

	logic signed [WORK_WIDTH-1:0] in_i;
	logic signed [WORK_WIDTH-1:0] in_q;
	logic                         fold;
	logic                         zero_vector;

	// Per-stage vector and accumulated angle
	logic signed [WORK_WIDTH-1:0] x [STAGES];
	logic signed [WORK_WIDTH-1:0] y [STAGES];
	iq_dir_pkg::angle_t           z [STAGES + 1];

	// Sign extend and scale up so the shifted terms keep precision
	assign in_i = {{EXT_BITS{i_sample.i[`IQ_WIDTH-1]}}, i_sample.i, {FRAC_BITS{1'b0}}};
	assign in_q = {{EXT_BITS{i_sample.q[`IQ_WIDTH-1]}}, i_sample.q, {FRAC_BITS{1'b0}}};

	// Quadrant pre-rotation
	// A negative I is mirrored through the origin, which costs half a turn
	assign fold = i_sample.i[`IQ_WIDTH-1];

	assign x[0] = fold ? -in_i : in_i;
	assign y[0] = fold ? -in_q : in_q;
	assign z[0] = fold ? HALF_TURN : '0;

	for (genvar k = 0; k < STAGES; k++) begin : g_stage
		logic rotate_cw;

		// Q at or above the axis so turn clockwise and add the step angle
		assign rotate_cw = !y[k][WORK_WIDTH-1];

		assign z[k+1] = rotate_cw ? z[k] + ATAN_LUT[k] : z[k] - ATAN_LUT[k];

		// The last stage only contributes to the angle
		if (k < STAGES - 1) begin : g_next
			logic signed [WORK_WIDTH-1:0] x_shift;
			logic signed [WORK_WIDTH-1:0] y_shift;

			assign x_shift = x[k] >>> k;
			assign y_shift = y[k] >>> k;

			assign x[k+1] = rotate_cw ? x[k] + y_shift : x[k] - y_shift;
			assign y[k+1] = rotate_cw ? y[k] - x_shift : y[k] + x_shift;
		end
	end

	// The zero vector has no phase so it reports the I axis
	assign zero_vector = (i_sample == '0);

	// Output register with the angle valid one cycle after the sample
	always_ff @(posedge clock) begin
		if (!reset) begin
			o_angle <= '0;
		end else if (zero_vector) begin
			o_angle <= '0;
		end else begin
			// Accumulator wraps modulo one turn so negative angles land in the upper range
			o_angle <= z[STAGES];
		end
	end

endmodule

// File: src/iq_dir_pkg.sv
`include "iq_dir_config.svh"

package iq_dir_pkg;

	// One complex sample with I in the upper half of the word
	typedef struct packed {
		logic signed [`IQ_WIDTH-1:0] i;
		logic signed [`IQ_WIDTH-1:0] q;
	} iq_sample_t;

	// Phase angle in fractions of a turn
	// 0 is the positive I axis and a quarter of full scale is +90 degrees
	typedef logic [`ANGLE_WIDTH-1:0] angle_t;

	// Top-level sequencer with one sample in flight at a time
	typedef enum logic [2:0] {
		IDLE,
		WAIT_ENABLE_IN,
		NEW_IQ_SAMPLE,
		TEMPO,
		UPDATE_DIRECTION,
		ACTIVATE_ENABLE_OUT
	} seq_state_t;

endpackage

// File: src/rotation.sv
`include "iq_dir_config.svh"

// Direction of phase rotation between consecutive samples
module rotation (
	input  logic               clock,
	input  logic               reset,
	input  iq_dir_pkg::angle_t i_angle,
	input  logic               i_update,
	output logic               o_dir
);

	iq_dir_pkg::angle_t      prev_angle;
	logic [`ANGLE_WIDTH-1:0] angle_delta;
	logic                    delta_negative;
	logic                    delta_zero;

	// Angle of the previous sample or the I axis after reset
	always_ff @(posedge clock) begin
		if (!reset) begin
			prev_angle <= '0;
		end else if (i_update) begin
			prev_angle <= i_angle;
		end
	end

	// Difference wraps modulo one turn
	// so a step across angle 0 keeps its true sign
	assign angle_delta = i_angle - prev_angle;

	assign delta_negative = angle_delta[`ANGLE_WIDTH-1];
	assign delta_zero = (angle_delta == '0);

	// Counterclockwise only for a strictly positive step
	assign o_dir = !delta_negative && !delta_zero;

endmodule

// File: src/system.sv
`include "iq_dir_config.svh"

// Phase rotation direction detector
// One sample goes through CORDIC and rotation per enable strobe
module system (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 i_enable_in,
	input  logic [`IQ_WIDTH-1:0] i_I,
	input  logic [`IQ_WIDTH-1:0] i_Q,
	output logic                 o_enable_out,
	output logic                 o_dir
);

	iq_dir_pkg::seq_state_t present_state;
	iq_dir_pkg::seq_state_t next_state;

	iq_dir_pkg::iq_sample_t sample;
	iq_dir_pkg::angle_t     cordic_angle;
	logic                   rotation_dir;
	logic                   update_dir;

	cordic_block cordic_inst (
		.clock    (clock),
		.reset    (reset),
		.i_sample (sample),
		.o_angle  (cordic_angle)
	);

	rotation rotation_inst (
		.clock    (clock),
		.reset    (reset),
		.i_angle  (cordic_angle),
		.i_update (update_dir),
		.o_dir    (rotation_dir)
	);

	// Previous angle moves on the same edge that latches o_dir
	assign update_dir = (present_state == iq_dir_pkg::UPDATE_DIRECTION);

	always_ff @(posedge clock) begin
		if (!reset) begin
			present_state <= iq_dir_pkg::IDLE;
		end else begin
			present_state <= next_state;
		end
	end

	// Sample register
	// Inputs are taken at the edge that ends NEW_IQ_SAMPLE
	always_ff @(posedge clock) begin
		if (!reset) begin
			sample <= '0;
		end else if (present_state == iq_dir_pkg::NEW_IQ_SAMPLE) begin
			sample.i <= i_I;
			sample.q <= i_Q;
		end
	end

	// Direction output holds its level between samples
	always_ff @(posedge clock) begin
		if (!reset) begin
			o_dir <= 1'b0;
		end else if (update_dir) begin
			o_dir <= rotation_dir;
		end
	end

	// TEMPO covers the CORDIC output register
	always_comb begin
		case (present_state)
			iq_dir_pkg::IDLE: begin
				next_state = iq_dir_pkg::WAIT_ENABLE_IN;
			end

			iq_dir_pkg::WAIT_ENABLE_IN: begin
				if (i_enable_in) begin
					next_state = iq_dir_pkg::NEW_IQ_SAMPLE;
				end else begin
					next_state = iq_dir_pkg::WAIT_ENABLE_IN;
				end
			end

			iq_dir_pkg::NEW_IQ_SAMPLE: begin
				next_state = iq_dir_pkg::TEMPO;
			end

			iq_dir_pkg::TEMPO: begin
				next_state = iq_dir_pkg::UPDATE_DIRECTION;
			end

			iq_dir_pkg::UPDATE_DIRECTION: begin
				next_state = iq_dir_pkg::ACTIVATE_ENABLE_OUT;
			end

			iq_dir_pkg::ACTIVATE_ENABLE_OUT: begin
				next_state = iq_dir_pkg::WAIT_ENABLE_IN;
			end

			// Unused encodings
			default: begin
				next_state = iq_dir_pkg::IDLE;
			end
		endcase
	end

	// One-cycle pulse once o_dir is valid
	assign o_enable_out = (present_state == iq_dir_pkg::ACTIVATE_ENABLE_OUT);

endmodule

// File: verif/system_assert.sv
// Protocol properties of the detector top level
module system_assert (
	input logic                   clock,
	input logic                   reset,
	input logic                   i_enable_in,
	input iq_dir_pkg::seq_state_t i_state,
	input logic                   i_enable_out,
	input logic                   i_dir
);

	// Read by the testbench at the end of the run
	int   failures = 0;
	logic accepted;

	// A strobe only counts while the sequencer waits for it
	assign accepted = (i_state == iq_dir_pkg::WAIT_ENABLE_IN) && i_enable_in;

	a_single_pulse: assert property (
		@(posedge clock) disable iff (!reset) i_enable_out |=> !i_enable_out
	) else begin
		failures++;
		$error("o_enable_out was high for two cycles in a row");
	end

	a_strobe_to_pulse: assert property (
		@(posedge clock) disable iff (!reset) accepted |-> ##4 i_enable_out
	) else begin
		failures++;
		$error("no o_enable_out pulse 4 cycles after an accepted strobe");
	end

	a_pulse_from_strobe: assert property (
		@(posedge clock) disable iff (!reset) i_enable_out |-> $past(accepted, 4)
	) else begin
		failures++;
		$error("o_enable_out pulse without an accepted strobe 4 cycles earlier");
	end

	// o_dir only moves on the edge into ACTIVATE_ENABLE_OUT
	a_dir_update: assert property (
		@(posedge clock) disable iff (!reset)
		$changed(i_dir) |-> (i_state == iq_dir_pkg::ACTIVATE_ENABLE_OUT)
	) else begin
		failures++;
		$error("o_dir changed outside ACTIVATE_ENABLE_OUT");
	end

	a_reset_outputs: assert property (
		@(posedge clock) !reset |=> (reset || (!i_enable_out && !i_dir))
	) else begin
		failures++;
		$error("outputs not zero during reset");
	end

endmodule

bind system system_assert system_assert_inst (
	.clock        (clock),
	.reset        (reset),
	.i_enable_in  (i_enable_in),
	.i_state      (present_state),
	.i_enable_out (o_enable_out),
	.i_dir        (o_dir)
);

// File: verif/system_checker.sv
// Compares o_dir at every o_enable_out pulse with the expected value
module system_checker (
	input  logic       clock,
	input  logic       reset,
	input  logic       i_enable_out,
	input  logic       i_dir,
	input  logic [7:0] i_test_id,
	input  logic       i_expected_dir,
	output int         o_pass_count,
	output int         o_fail_count
);

	// Test that has already seen its pulse
	logic [7:0] last_id;

	always @(posedge clock) begin
		if (!reset) begin
			o_pass_count <= 0;
			o_fail_count <= 0;
			last_id <= '0;
		end else if (i_enable_out) begin
			if (i_test_id == '0 || i_test_id == last_id) begin
				// Either no strobe yet or a second pulse for one strobe
				o_fail_count <= o_fail_count + 1;
				$display("Unexpected o_enable_out pulse at %0t, no strobe was pending",
					$time);
			end else if (i_dir !== i_expected_dir) begin
				o_fail_count <= o_fail_count + 1;
				last_id <= i_test_id;
				$display("Mismatch at %0t: o_dir got %0b expected %0b (test %0d)",
					$time, i_dir, i_expected_dir, i_test_id);
			end else begin
				o_pass_count <= o_pass_count + 1;
				last_id <= i_test_id;
				$display("Test %0d ok at %0t: o_dir %0b", i_test_id, $time, i_dir);
			end
		end
	end

endmodule

// File: verif/system_tb.sv
`include "iq_dir_config.svh"

module system_tb;

	localparam int NUM_ROWS = 20;
	localparam int PULSE_TIMEOUT = 20;
	localparam int LATENCY = 4;

	// Strobe held through processing when hold is set
	typedef struct packed {
		logic [`IQ_WIDTH-1:0] i;
		logic [`IQ_WIDTH-1:0] q;
		logic                 dir;
		logic                 hold;
		logic                 rand_gap;
		logic [2:0]           gap;
	} test_row_t;

	logic                 clock;
	logic                 reset;
	logic                 i_enable_in;
	logic [`IQ_WIDTH-1:0] i_I;
	logic [`IQ_WIDTH-1:0] i_Q;
	logic                 o_enable_out;
	logic                 o_dir;
	logic [7:0]           test_id;
	logic                 expected_dir;
	int                   pass_count;
	int                   fail_count;
	int                   tb_errors;

	// Angles in degrees in the row comments with the previous angle at 0 after reset
	test_row_t rows [NUM_ROWS] = '{
		'{4'sd3, 4'sd3, 1'b1, 1'b0, 1'b0, 3'd0},     // 45
		'{4'sd5, 4'sd0, 1'b0, 1'b0, 1'b0, 3'd2},     // 0
		'{4'sd3, 4'sd3, 1'b1, 1'b0, 1'b1, 3'd0},     // 45
		'{4'sd0, 4'sd5, 1'b1, 1'b0, 1'b1, 3'd0},     // 90
		'{-4'sd5, 4'sd2, 1'b1, 1'b0, 1'b1, 3'd0},    // 158
		'{-4'sd3, -4'sd3, 1'b1, 1'b0, 1'b0, 3'd1},   // 225
		'{4'sd0, -4'sd6, 1'b1, 1'b0, 1'b1, 3'd0},    // 270
		'{4'sd4, -4'sd4, 1'b1, 1'b0, 1'b0, 3'd0},    // 315
		'{4'sd5, 4'sd2, 1'b1, 1'b0, 1'b1, 3'd0},     // 22 across 0
		'{4'sd5, -4'sd3, 1'b0, 1'b0, 1'b0, 3'd3},    // 329 back across 0
		'{4'sd0, -4'sd5, 1'b0, 1'b0, 1'b1, 3'd0},    // 270
		'{-4'sd4, -4'sd4, 1'b0, 1'b0, 1'b1, 3'd0},   // 225
		'{-4'sd5, 4'sd0, 1'b0, 1'b0, 1'b0, 3'd0},    // 180
		'{4'sd0, 4'sd5, 1'b0, 1'b0, 1'b1, 3'd0},     // 90
		'{4'sd3, 4'sd3, 1'b0, 1'b0, 1'b0, 3'd4},     // 45
		'{-4'sd3, 4'sd3, 1'b1, 1'b1, 1'b0, 3'd0},    // 135
		'{4'sd0, -4'sd5, 1'b1, 1'b1, 1'b1, 3'd0},    // 270
		'{4'sd5, 4'sd0, 1'b1, 1'b0, 1'b1, 3'd0},     // 0
		'{4'sd3, -4'sd5, 1'b0, 1'b0, 1'b1, 3'd0},    // 301
		'{-4'sd2, -4'sd5, 1'b0, 1'b0, 1'b0, 3'd1}    // 248
	};

	system system_inst (
		.clock        (clock),
		.reset        (reset),
		.i_enable_in  (i_enable_in),
		.i_I          (i_I),
		.i_Q          (i_Q),
		.o_enable_out (o_enable_out),
		.o_dir        (o_dir)
	);

	system_checker result_checker (
		.clock          (clock),
		.reset          (reset),
		.i_enable_out   (o_enable_out),
		.i_dir          (o_dir),
		.i_test_id      (test_id),
		.i_expected_dir (expected_dir),
		.o_pass_count   (pass_count),
		.o_fail_count   (fail_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// No strobe, so both outputs must stay low
	task automatic check_quiet_outputs(input int n_cycles);
		for (int c = 0; c < n_cycles; c++) begin
			@(negedge clock);
			if (o_enable_out !== 1'b0) begin
				tb_errors++;
				$display("Mismatch at %0t: o_enable_out got %0b expected 0",
					$time, o_enable_out);
			end
			if (o_dir !== 1'b0) begin
				tb_errors++;
				$display("Mismatch at %0t: o_dir got %0b expected 0",
					$time, o_dir);
			end
		end
	endtask

	task automatic apply_row(input int n);
		test_row_t row;
		int        gap;
		int        cycles;
		logic      seen;

		row = rows[n];
		gap = row.rand_gap ? int'($urandom % 6) : int'(row.gap);
		repeat (gap) @(negedge clock);
		// One more edge so the checker has sampled the previous pulse
		@(negedge clock);
		i_I = row.i;
		i_Q = row.q;
		expected_dir = row.dir;
		test_id = 8'(n + 1);
		i_enable_in = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < PULSE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
			i_enable_in = row.hold && (cycles < LATENCY);
			seen = o_enable_out;
		end
		if (!seen) begin
			i_enable_in = 1'b0;
			tb_errors++;
			$display("Test %0d failed: no o_enable_out pulse within %0d cycles at %0t",
				n + 1, PULSE_TIMEOUT, $time);
		end else if (cycles != LATENCY) begin
			tb_errors++;
			$display("Mismatch at %0t: o_enable_out latency got %0d expected %0d",
				$time, cycles, LATENCY);
		end
		// A held strobe must not start a second sample
		if (row.hold) begin
			check_quiet_pulse(6);
		end
	endtask

	task automatic check_quiet_pulse(input int n_cycles);
		for (int c = 0; c < n_cycles; c++) begin
			@(negedge clock);
			if (o_enable_out !== 1'b0) begin
				tb_errors++;
				$display("Mismatch at %0t: o_enable_out got %0b expected 0",
					$time, o_enable_out);
			end
		end
	endtask

	initial begin
		int total_errors;
		int assert_failures;

		void'($urandom(32'hb4939e1c));
		reset = 1'b0;
		i_enable_in = 1'b0;
		i_I = '0;
		i_Q = '0;
		test_id = '0;
		expected_dir = 1'b0;
		tb_errors = 0;
		repeat (16) @(negedge clock);
		reset = 1'b1;
		check_quiet_outputs(6);
		for (int n = 0; n < NUM_ROWS; n++) begin
			apply_row(n);
		end
		repeat (4) @(negedge clock);
		if (pass_count + fail_count != NUM_ROWS) begin
			tb_errors++;
			$display("Checker compared %0d results for %0d tests",
				pass_count + fail_count, NUM_ROWS);
		end
		assert_failures = system_inst.system_assert_inst.failures;
		total_errors = tb_errors + fail_count + assert_failures;
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertions",
			NUM_ROWS, pass_count, fail_count, tb_errors, assert_failures);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
